// File: hw/spi_cfg_pkg.sv
package spi_cfg_pkg;

    // {cpol, cpha}
    typedef enum logic [1:0] {
        MODE0 = 2'b00, // idle low, sample on rise
        MODE1 = 2'b01, // idle low, sample on fall
        MODE2 = 2'b10, // idle high, sample on fall
        MODE3 = 2'b11  // idle high, sample on rise
    } spi_mode_e;

    // rev = 1 selects msb first
    typedef enum logic {
        LSB_FIRST = 1'b0,
        MSB_FIRST = 1'b1
    } bit_order_e;

    // length field holds bits minus one
    localparam int CHAR_LEN_W = 4;

endpackage

// File: hw/spi_stat_pkg.sv
package spi_stat_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'd0, // cs inactive
        ACTIVE = 2'd1, // character in flight
        DONE   = 2'd2  // one-cycle character end
    } ctrl_state_e;

    localparam int CNT_W = 8; // character counter width

endpackage

// File: hw/spi_pin_sync.sv
`timescale 1ns/100ps

module spi_pin_sync
    import spi_cfg_pkg::*;
(
    input  logic S_SYSCLK,
    input  logic S_RESETN,
    input  logic enable,
    input  logic cpol,
    input  logic cpha,
    input  logic cspol,
    input  logic spi_cs,
    input  logic spi_sck,
    input  logic spi_mosi,
    output logic slave_active,
    output logic frame_start,
    output logic sample_pulse,
    output logic launch_pulse,
    output logic mosi_s
);

    logic [1:0] cs_sync;
    logic [1:0] sck_sync;
    logic [1:0] mosi_sync;
    logic       sck_dly;
    logic       active_dly;
    logic       cs_hit;
    logic       sck_rise;
    logic       sck_fall;
    spi_mode_e  mode;

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            cs_sync    <= {2{cspol}}; // park on the inactive level
            sck_sync   <= {2{cpol}};
            mosi_sync  <= 2'b00;
            sck_dly    <= cpol;
            active_dly <= 1'b0;
        end else begin
            cs_sync    <= {cs_sync[0], spi_cs};
            sck_sync   <= {sck_sync[0], spi_sck};
            mosi_sync  <= {mosi_sync[0], spi_mosi};
            sck_dly    <= sck_sync[1];
            active_dly <= slave_active;
        end
    end

    assign cs_hit       = cspol ? ~cs_sync[1] : cs_sync[1]; // cspol set means cs active low
    assign slave_active = enable & cs_hit;
    assign frame_start  = slave_active & ~active_dly;
    assign sck_rise     = slave_active & sck_sync[1] & ~sck_dly;
    assign sck_fall     = slave_active & ~sck_sync[1] & sck_dly;
    assign mosi_s       = mosi_sync[1];
    assign mode         = spi_mode_e'({cpol, cpha});

    // cpha 0 launches the first bit on cs, the rest on the trailing edge
    always_comb begin
        case (mode)
            MODE0: begin
                sample_pulse = sck_rise;
                launch_pulse = sck_fall | frame_start;
            end
            MODE1: begin
                sample_pulse = sck_fall;
                launch_pulse = sck_rise;
            end
            MODE2: begin
                sample_pulse = sck_fall;
                launch_pulse = sck_rise | frame_start;
            end
            MODE3: begin
                sample_pulse = sck_rise;
                launch_pulse = sck_fall;
            end
            default: begin
                sample_pulse = 1'b0;
                launch_pulse = 1'b0;
            end
        endcase
    end

    a_no_overlap: assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        !(sample_pulse && launch_pulse));

endmodule

// File: hw/spi_rx_path.sv
`timescale 1ns/100ps

module spi_rx_path
    import spi_cfg_pkg::*;
#(
    parameter int CHAR_NBITS = 16
) (
    input  logic                  S_SYSCLK,
    input  logic                  S_RESETN,
    input  logic                  slave_active,
    input  logic                  sample_pulse,
    input  logic                  mosi_s,
    input  logic                  rev,
    input  logic [CHAR_LEN_W-1:0] char_len,
    output logic [CHAR_NBITS-1:0] rx_char,
    output logic                  rx_end
);

    logic [CHAR_LEN_W-1:0] bit_cnt;
    logic [CHAR_LEN_W-1:0] bit_pos;
    logic [CHAR_NBITS-1:0] rx_shift;
    logic [CHAR_NBITS-1:0] rx_next;
    bit_order_e            order;

    assign order   = bit_order_e'(rev);
    assign bit_pos = (order == MSB_FIRST) ? char_len - bit_cnt : bit_cnt;
    assign rx_end  = sample_pulse && (bit_cnt == char_len);

    // current bit merged in, so the last sample is part of rx_char at rx_end
    always_comb begin
        rx_next = (bit_cnt == '0) ? '0 : rx_shift; // first bit clears old upper bits
        if (int'(bit_pos) < CHAR_NBITS) begin
            rx_next[bit_pos] = mosi_s;
        end
    end

    assign rx_char = rx_next;

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            bit_cnt <= '0;
        end else if (!slave_active) begin
            bit_cnt <= '0; // restart on cs release
        end else if (sample_pulse) begin
            bit_cnt <= rx_end ? '0 : bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (sample_pulse) begin
            rx_shift <= rx_next;
        end
    end

endmodule

// File: hw/spi_tx_path.sv
`timescale 1ns/100ps

module spi_tx_path
    import spi_cfg_pkg::*;
#(
    parameter int CHAR_NBITS = 16
) (
    input  logic                  S_SYSCLK,
    input  logic                  S_RESETN,
    input  logic                  slave_active,
    input  logic                  frame_start,
    input  logic                  launch_pulse,
    input  logic                  rev,
    input  logic [CHAR_LEN_W-1:0] char_len,
    input  logic [CHAR_NBITS-1:0] wchar,
    input  logic                  wchar_load,
    output logic                  spi_miso,
    output logic                  miso_en,
    output logic                  tx_take
);

    logic [CHAR_NBITS-1:0] wchar_hold;
    logic [CHAR_NBITS-1:0] tx_shift;
    logic [CHAR_NBITS-1:0] tx_src;
    logic [CHAR_LEN_W-1:0] tx_cnt;
    logic [CHAR_LEN_W-1:0] bit_pos;
    logic                  tx_bit;
    logic                  miso_q;
    bit_order_e            order;

    assign order   = bit_order_e'(rev);
    assign bit_pos = (order == MSB_FIRST) ? char_len - tx_cnt : tx_cnt;
    assign tx_take = launch_pulse && (tx_cnt == '0);
    assign tx_src  = tx_take ? wchar_hold : tx_shift; // first bit straight from holding reg
    assign tx_bit  = (int'(bit_pos) < CHAR_NBITS) ? tx_src[bit_pos] : 1'b0;

    always_ff @(posedge S_SYSCLK) begin
        if (wchar_load) begin
            wchar_hold <= wchar;
        end
        if (tx_take) begin
            tx_shift <= wchar_hold; // character being sent
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            tx_cnt <= '0;
            miso_q <= 1'b0;
        end else begin
            if (!slave_active) begin
                tx_cnt <= '0;
            end else if (launch_pulse) begin
                tx_cnt <= (tx_cnt == char_len) ? '0 : tx_cnt + 1'b1;
            end
            if (launch_pulse) begin
                miso_q <= tx_bit;
            end else if (frame_start) begin
                miso_q <= 1'b0; // no stale bit from the last frame
            end
        end
    end

    assign miso_en  = slave_active;
    assign spi_miso = slave_active & miso_q;

    // char_len must stay put while a frame runs
    a_cnt_in_len: assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        slave_active |-> (tx_cnt <= char_len));

endmodule

// File: hw/spi_char_ctrl.sv
`timescale 1ns/100ps

module spi_char_ctrl
    import spi_stat_pkg::*;
#(
    parameter int CHAR_NBITS = 16
) (
    input  logic                  S_SYSCLK,
    input  logic                  S_RESETN,
    input  logic                  slave_active,
    input  logic                  rx_end,
    input  logic [CHAR_NBITS-1:0] rx_char,
    input  logic                  tx_take,
    input  logic                  wchar_load,
    output logic                  char_done,
    output logic [CHAR_NBITS-1:0] rchar,
    output logic [CNT_W-1:0]      char_cnt,
    output logic                  underrun
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        char_end;
    logic        fresh;
    logic        first_take;

    assign char_end  = (state == ACTIVE) && slave_active && rx_end;
    assign char_done = (state == DONE);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (slave_active) begin
                    state_nxt = ACTIVE;
                end
            end
            ACTIVE: begin
                if (!slave_active) begin
                    state_nxt = IDLE;
                end else if (rx_end) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                state_nxt = slave_active ? ACTIVE : IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge S_SYSCLK) begin
        if (!S_RESETN) begin
            state      <= IDLE;
            rchar      <= '0;
            char_cnt   <= '0;
            fresh      <= 1'b0;
            first_take <= 1'b1;
            underrun   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (char_end) begin
                rchar    <= rx_char;
                char_cnt <= char_cnt + 1'b1; // free-running, wraps
            end
            if (wchar_load) begin
                fresh <= 1'b1; // a load alongside a take belongs to the next char
            end else if (tx_take) begin
                fresh <= 1'b0;
            end
            if (!slave_active) begin
                first_take <= 1'b1;
                underrun   <= 1'b0;
            end else if (tx_take) begin
                first_take <= 1'b0;
                if (!fresh && !first_take) begin
                    underrun <= 1'b1; // previous wchar goes out again
                end
            end
        end
    end

    // an end outside ACTIVE would be dropped
    a_end_in_active: assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        rx_end |-> (state == ACTIVE));

endmodule

// File: hw/spi_slave_trx.sv
`timescale 1ns/100ps

module spi_slave_trx
    import spi_cfg_pkg::*;
    import spi_stat_pkg::*;
#(
    parameter int CHAR_NBITS = 16
) (
    input  logic                  S_SYSCLK,
    input  logic                  S_RESETN,
    input  logic                  enable,
    input  logic                  cpol,
    input  logic                  cpha,
    input  logic                  cspol,
    input  logic                  rev,
    input  logic [CHAR_LEN_W-1:0] char_len,
    input  logic [CHAR_NBITS-1:0] wchar,
    input  logic                  wchar_load,
    input  logic                  spi_cs,
    input  logic                  spi_sck,
    input  logic                  spi_mosi,
    output logic                  spi_miso,
    output logic                  miso_en,
    output logic                  char_done,
    output logic [CHAR_NBITS-1:0] rchar,
    output logic [CNT_W-1:0]      char_cnt,
    output logic                  underrun
);

    logic                  slave_active;
    logic                  frame_start;
    logic                  sample_pulse;
    logic                  launch_pulse;
    logic                  mosi_s;
    logic [CHAR_NBITS-1:0] rx_char;
    logic                  rx_end;
    logic                  tx_take;

    spi_pin_sync i_pin_sync (
        .S_SYSCLK     (S_SYSCLK),
        .S_RESETN     (S_RESETN),
        .enable       (enable),
        .cpol         (cpol),
        .cpha         (cpha),
        .cspol        (cspol),
        .spi_cs       (spi_cs),
        .spi_sck      (spi_sck),
        .spi_mosi     (spi_mosi),
        .slave_active (slave_active),
        .frame_start  (frame_start),
        .sample_pulse (sample_pulse),
        .launch_pulse (launch_pulse),
        .mosi_s       (mosi_s)
    );

    spi_rx_path #(
        .CHAR_NBITS (CHAR_NBITS)
    ) i_rx_path (
        .S_SYSCLK     (S_SYSCLK),
        .S_RESETN     (S_RESETN),
        .slave_active (slave_active),
        .sample_pulse (sample_pulse),
        .mosi_s       (mosi_s),
        .rev          (rev),
        .char_len     (char_len),
        .rx_char      (rx_char),
        .rx_end       (rx_end)
    );

    spi_tx_path #(
        .CHAR_NBITS (CHAR_NBITS)
    ) i_tx_path (
        .S_SYSCLK     (S_SYSCLK),
        .S_RESETN     (S_RESETN),
        .slave_active (slave_active),
        .frame_start  (frame_start),
        .launch_pulse (launch_pulse),
        .rev          (rev),
        .char_len     (char_len),
        .wchar        (wchar),
        .wchar_load   (wchar_load),
        .spi_miso     (spi_miso),
        .miso_en      (miso_en),
        .tx_take      (tx_take)
    );

    spi_char_ctrl #(
        .CHAR_NBITS (CHAR_NBITS)
    ) i_char_ctrl (
        .S_SYSCLK     (S_SYSCLK),
        .S_RESETN     (S_RESETN),
        .slave_active (slave_active),
        .rx_end       (rx_end),
        .rx_char      (rx_char),
        .tx_take      (tx_take),
        .wchar_load   (wchar_load),
        .char_done    (char_done),
        .rchar        (rchar),
        .char_cnt     (char_cnt),
        .underrun     (underrun)
    );

endmodule

// File: bench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter real PERIOD     = 20.0,
    parameter int  RST_CYCLES = 3
) (
    output logic S_SYSCLK,
    output logic S_RESETN
);

    initial begin
        S_SYSCLK = 1'b0;
        forever #(PERIOD / 2.0) S_SYSCLK = ~S_SYSCLK;
    end

    initial begin
        S_RESETN = 1'b0;
        repeat (RST_CYCLES) @(posedge S_SYSCLK);
        S_RESETN <= 1'b1;
    end

endmodule

// File: bench/tb_spi_slave_trx.sv
`timescale 1ns/100ps

module tb_spi_slave_trx
    import spi_cfg_pkg::*;
    import spi_stat_pkg::*;
();

    localparam int NB        = 16;
    localparam int N_FRAMES  = 64;
    localparam int FRAME_CYC = 40 + 4 * 16 * 2 * 8; // worst case frame
    localparam int IDLE_CYC  = 24 * 4 + 40;
    localparam int CYC_LIMIT = 2 * (N_FRAMES * FRAME_CYC + 4 * IDLE_CYC + 20);

    logic                  S_SYSCLK;
    logic                  S_RESETN;
    logic                  enable;
    logic                  cpol;
    logic                  cpha;
    logic                  cspol;
    logic                  rev;
    logic [CHAR_LEN_W-1:0] char_len;
    logic [NB-1:0]         wchar;
    logic                  wchar_load;
    logic                  spi_cs;
    logic                  spi_sck;
    logic                  spi_mosi;
    logic                  spi_miso;
    logic                  miso_en;
    logic                  char_done;
    logic [NB-1:0]         rchar;
    logic [CNT_W-1:0]      char_cnt;
    logic                  underrun;

    logic [NB-1:0] exp_rx_q[$]; // model: characters awaiting char_done
    logic          exp_un_q[$];
    logic [NB-1:0] rx_a[4];
    logic [NB-1:0] ld_a[4];
    logic          skip_a[4];
    logic [NB-1:0] mask_f;
    logic [NB-1:0] miso_acc;
    bit_order_e    order_f;
    int            len_f;
    int            n_chars_f;
    int            half;
    int            err_val = 0;
    int            err_other = 0;
    int            n_sent = 0;
    int            n_done = 0;
    int            cycles = 0;

    tb_clk_gen i_clk_gen (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN)
    );

    spi_slave_trx #(
        .CHAR_NBITS (NB)
    ) i_dut (
        .S_SYSCLK   (S_SYSCLK),
        .S_RESETN   (S_RESETN),
        .enable     (enable),
        .cpol       (cpol),
        .cpha       (cpha),
        .cspol      (cspol),
        .rev        (rev),
        .char_len   (char_len),
        .wchar      (wchar),
        .wchar_load (wchar_load),
        .spi_cs     (spi_cs),
        .spi_sck    (spi_sck),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso),
        .miso_en    (miso_en),
        .char_done  (char_done),
        .rchar      (rchar),
        .char_cnt   (char_cnt),
        .underrun   (underrun)
    );

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            err_val++;
            $display("ERR %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic wait_clk(input int n);
        repeat (n) @(posedge S_SYSCLK);
    endtask

    // half an sck period, load strobe dropped after one clock
    task automatic hold_half();
        wait_clk(1);
        wchar_load <= 1'b0;
        wait_clk(half - 1);
    endtask

    function automatic int bit_idx(input int i);
        return (order_f == MSB_FIRST) ? len_f - i : i;
    endfunction

    // master sampling edge: read miso, feed host, record the model
    task automatic sample_bit(input int c, input int i);
        int   k;
        logic un;
        check_val("miso_en", 1, miso_en);
        miso_acc[bit_idx(i)] = spi_miso;
        if (i == 0 && c + 1 < n_chars_f && !skip_a[c + 1]) begin
            wchar      <= ld_a[c + 1];
            wchar_load <= 1'b1;
        end
        if (i == len_f) begin
            un = 1'b0;
            for (k = 1; k <= c; k++) begin
                un = un | skip_a[k]; // skipped load means repeat and underrun
            end
            exp_rx_q.push_back(rx_a[c] & mask_f);
            exp_un_q.push_back(un);
            check_val("spi_miso char", ld_a[c] & mask_f, miso_acc);
            miso_acc = '0;
        end
    endtask

    task automatic run_frame();
        spi_mode_e mode;
        logic      cs_off;
        logic      cpol_l;
        logic      cpha_l;
        int        c;
        int        i;
        mode      = spi_mode_e'($urandom_range(3, 0));
        cpol_l    = mode[1];
        cpha_l    = mode[0];
        cs_off    = $urandom_range(1, 0);
        order_f   = bit_order_e'($urandom_range(1, 0));
        len_f     = $urandom_range(15, 0);
        n_chars_f = $urandom_range(4, 1);
        half      = $urandom_range(8, 4);
        mask_f    = NB'((32'd1 << (len_f + 1)) - 1);
        miso_acc  = '0;
        for (c = 0; c < n_chars_f; c++) begin
            rx_a[c]   = NB'($urandom);
            skip_a[c] = (c > 0) && ($urandom_range(3, 0) == 0);
            ld_a[c]   = skip_a[c] ? ld_a[c - 1] : NB'($urandom);
        end
        wait_clk(1);
        enable <= 1'b0; // reconfigure with the slave off
        wait_clk(1);
        {cpol, cpha} <= mode;
        cspol      <= cs_off;
        spi_cs     <= cs_off;
        spi_sck    <= cpol_l;
        rev        <= order_f;
        char_len   <= CHAR_LEN_W'(len_f);
        wchar      <= ld_a[0];
        wchar_load <= 1'b1;
        wait_clk(1);
        wchar_load <= 1'b0;
        wait_clk(5);
        enable <= 1'b1;
        wait_clk(4);
        spi_cs   <= ~cs_off;
        spi_mosi <= rx_a[0][bit_idx(0)];
        hold_half();
        for (c = 0; c < n_chars_f; c++) begin
            for (i = 0; i <= len_f; i++) begin
                spi_sck <= ~cpol_l; // leading edge
                if (cpha_l) begin
                    spi_mosi <= rx_a[c][bit_idx(i)];
                end else begin
                    sample_bit(c, i);
                end
                hold_half();
                spi_sck <= cpol_l; // trailing edge
                if (cpha_l) begin
                    sample_bit(c, i);
                end else if (i < len_f) begin
                    spi_mosi <= rx_a[c][bit_idx(i + 1)];
                end else if (c + 1 < n_chars_f) begin
                    spi_mosi <= rx_a[c + 1][bit_idx(0)];
                end
                hold_half();
            end
        end
        spi_cs <= cs_off;
        wait_clk(10);
        assert (exp_rx_q.size() == 0) else begin
            err_other++;
            $display("%0d character(s) finished without a char_done", exp_rx_q.size());
            exp_rx_q.delete();
            exp_un_q.delete();
        end
        check_val("underrun", 0, underrun);
        n_sent += n_chars_f;
    endtask

    // sck activity with cs inactive (en_l high) or with enable low
    task automatic idle_toggle(input logic en_l);
        int k;
        wait_clk(1);
        enable <= 1'b0;
        wait_clk(4);
        spi_cs <= en_l ? cspol : ~cspol;
        wait_clk(4);
        enable <= en_l;
        for (k = 0; k < 24; k++) begin
            spi_sck  <= ~spi_sck;
            spi_mosi <= $urandom_range(1, 0);
            repeat (4) begin
                wait_clk(1);
                check_val("miso_en", 0, miso_en);
                check_val("spi_miso", 0, spi_miso);
            end
        end
        enable  <= 1'b0;
        spi_cs  <= cspol;
        spi_sck <= cpol;
        wait_clk(8);
    endtask

    always @(negedge S_SYSCLK) begin
        if (S_RESETN && char_done) begin
            n_done++;
            assert (exp_rx_q.size() > 0) else begin
                err_other++;
                $display("char_done seen with no character sent");
            end
            if (exp_rx_q.size() > 0) begin
                check_val("rchar", exp_rx_q.pop_front(), rchar);
                check_val("underrun", exp_un_q.pop_front(), underrun);
            end
        end
    end

    always @(posedge S_SYSCLK) begin
        cycles++;
        if (cycles > CYC_LIMIT) begin
            err_other++;
            $display("timeout: run still busy after %0d clock cycles", cycles);
            $display("errors: %0d value mismatches, %0d other failures", err_val, err_other);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        void'($urandom(62248));
        enable     <= 1'b0;
        cpol       <= 1'b0;
        cpha       <= 1'b0;
        cspol      <= 1'b0;
        rev        <= 1'b0;
        char_len   <= '0;
        wchar      <= '0;
        wchar_load <= 1'b0;
        spi_cs     <= 1'b0; // inactive for cspol 0
        spi_sck    <= 1'b0;
        spi_mosi   <= 1'b0;
        wait (S_RESETN === 1'b1);
        wait_clk(1);
        check_val("char_done", 0, char_done);
        check_val("miso_en", 0, miso_en);
        check_val("underrun", 0, underrun);
        check_val("rchar", 0, rchar);
        check_val("char_cnt", 0, char_cnt);
        idle_toggle(1'b1);
        idle_toggle(1'b0);
        repeat (N_FRAMES) begin
            run_frame();
        end
        idle_toggle(1'b1);
        idle_toggle(1'b0);
        wait_clk(10);
        check_val("char_cnt", n_sent % 256, char_cnt);
        assert (n_done == n_sent) else begin
            err_other++;
            $display("saw %0d char_done pulses for %0d characters sent", n_done, n_sent);
        end
        $display("errors: %0d value mismatches, %0d other failures", err_val, err_other);
        if (err_val + err_other == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: list.f
hw/spi_cfg_pkg.sv
hw/spi_stat_pkg.sv
hw/spi_pin_sync.sv
hw/spi_rx_path.sv
hw/spi_tx_path.sv
hw/spi_char_ctrl.sv
hw/spi_slave_trx.sv
bench/tb_clk_gen.sv
bench/tb_spi_slave_trx.sv
